// File: source/asg_pkg.sv
//////////////////////////////////////////////////
// shared types for the signal generator
// sample, bus address and burst counter widths
// CPU bus request, burst config, stream sample
// run state encoding
//////////////////////////////////////////////////

package asg_pkg;

  // one DAC sample
  typedef logic [14-1:0] smp_t;

  // CPU word address, table uses the low bits
  typedef logic [16-1:0] bus_adr_t;

  // burst data/period length count
  typedef logic [32-1:0] bln_t;

  // burst repetition count
  typedef logic [16-1:0] bnm_t;

  // CPU bus request, 32 bits
  typedef struct packed {
    logic     wen;
    logic     ren;
    bus_adr_t addr;
    smp_t     wdata;
  } bus_req_t;

  // burst configuration, lengths are minus one
  typedef struct packed {
    logic ben;  // burst enable
    logic inf;  // repeat forever
    bln_t bdl;  // data length
    bln_t bln;  // period length
    bnm_t bnm;  // repetitions
  } bst_cfg_t;

  // stream sample with last flag
  typedef struct packed {
    smp_t dat;
    logic lst;
  } stm_smp_t;

  // run state machine
  typedef enum logic [1:0] {
    ST_STOP,
    ST_ARMED,
    ST_DATA,
    ST_GAP
  } run_state_e;

endpackage

// File: source/asg_ctl.sv
//////////////////////////////////////////////////
// run state machine of the generator
// arm, trigger, burst data/gap, stop
// pointer, read and counter controls, period event
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_ctl (
  input  logic              sto,
  input  logic              ctl_rst,
  input  logic              ctl_str,
  input  logic              ctl_stp,
  input  logic              ctl_trg,
  input  asg_pkg::bst_cfg_t cfg_bst,
  input  logic              pipe_adv,
  input  logic              end_bdl,
  input  logic              end_bln,
  input  logic              end_bnm,
  output logic              sts_str,
  output logic              sts_trg,
  output logic              ptr_ld,
  output logic              ptr_en,
  output logic              rd_en,
  output logic              rd_lst,
  output logic              cnt_clr,
  output logic              cnt_en,
  output logic              evn_per
);

  asg_pkg::run_state_e state;
  asg_pkg::run_state_e state_nxt;
  logic run;
  logic run_go;
  logic rpt;
  logic run_end;

  //////////////////////////////////////////////////
  // events
  //////////////////////////////////////////////////

  // running covers both data and gap
  assign run = (state == asg_pkg::ST_DATA) || (state == asg_pkg::ST_GAP);
  // trigger while armed, or in the same cycle as start
  assign run_go = ctl_trg & ~ctl_stp &
                  ((state == asg_pkg::ST_ARMED) | ((state == asg_pkg::ST_STOP) & ctl_str));
  // end of a burst period
  assign rpt = cfg_bst.ben & run & end_bln;
  // stop request or last period done
  assign run_end = run & (ctl_stp | (rpt & end_bnm));

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    unique case (state)
      asg_pkg::ST_STOP: begin
        if (ctl_str & ~ctl_stp) begin
          state_nxt = run_go ? asg_pkg::ST_DATA : asg_pkg::ST_ARMED;
        end
      end
      asg_pkg::ST_ARMED: begin
        if (ctl_stp) begin
          state_nxt = asg_pkg::ST_STOP;
        end else if (run_go) begin
          state_nxt = asg_pkg::ST_DATA;
        end
      end
      asg_pkg::ST_DATA: begin
        // triggers are ignored while running
        if (run_end) begin
          state_nxt = asg_pkg::ST_STOP;
        end else if (cfg_bst.ben & end_bdl & ~rpt) begin
          state_nxt = asg_pkg::ST_GAP;
        end
      end
      default: begin
        // gap, leave at period end or if burst mode got switched off
        if (run_end) begin
          state_nxt = asg_pkg::ST_STOP;
        end else if (rpt | ~cfg_bst.ben) begin
          state_nxt = asg_pkg::ST_DATA;
        end
      end
    endcase
  end

  // whole pipeline moves on pipe_adv only
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state <= asg_pkg::ST_STOP;
    end else if (pipe_adv) begin
      state <= state_nxt;
    end
  end

  // one cycle pulse after each period end
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      evn_per <= 1'b0;
    end else begin
      evn_per <= pipe_adv & rpt;
    end
  end

  //////////////////////////////////////////////////
  // controls
  //////////////////////////////////////////////////

  assign sts_str = (state != asg_pkg::ST_STOP);
  assign sts_trg = run;
  assign ptr_ld  = run_go;
  assign cnt_clr = run_go;
  assign cnt_en  = run;
  // gap cycles reread the held address
  assign rd_en   = run;
  assign rd_lst  = run_end;
  // pointer holds on the last data address through the gap
  assign ptr_en  = ((state == asg_pkg::ST_DATA) & ~(cfg_bst.ben & end_bdl)) |
                   (rpt & ~end_bnm);

endmodule

// File: source/asg_burst_cnt.sv
//////////////////////////////////////////////////
// burst period and repetition counters
// with data, period and repetition end flags
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_burst_cnt (
  input  logic              sto,
  input  logic              ctl_rst,
  input  logic              pipe_adv,
  input  logic              cnt_clr,
  input  logic              cnt_en,
  input  asg_pkg::bst_cfg_t cfg_bst,
  output asg_pkg::bln_t     sts_bln,
  output asg_pkg::bnm_t     sts_bnm,
  output logic              end_bdl,
  output logic              end_bln,
  output logic              end_bnm
);

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////

  // period counter restarts at period end
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_bln <= '0;
    end else if (pipe_adv) begin
      if (cnt_clr) begin
        sts_bln <= '0;
      end else if (cnt_en) begin
        sts_bln <= end_bln ? '0 : sts_bln + 1'b1;
      end
    end
  end

  // repetitions, one step per period
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_bnm <= '0;
    end else if (pipe_adv) begin
      if (cnt_clr) begin
        sts_bnm <= '0;
      end else if (cnt_en & end_bln) begin
        sts_bnm <= sts_bnm + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // end flags
  //////////////////////////////////////////////////

  // last data cycle of the period
  assign end_bdl = (sts_bln == cfg_bst.bdl);
  // last cycle of the period
  assign end_bln = (sts_bln == cfg_bst.bln);
  // never the last period in infinite mode
  assign end_bnm = (sts_bnm == cfg_bst.bnm) & ~cfg_bst.inf;

endmodule

// File: source/asg_ptr.sv
//////////////////////////////////////////////////
// fixed point phase accumulator
// offset load, step add, modulo wrap on size
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_ptr #(
  parameter int unsigned CWM = 14,
  parameter int unsigned CWF = 16
) (
  input  logic               sto,
  input  logic               ctl_rst,
  input  logic               pipe_adv,
  input  logic               ptr_ld,
  input  logic               ptr_en,
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_ste,
  input  logic [CWM+CWF-1:0] cfg_off,
  output logic [CWM-1:0]     rd_adr
);

  // two guard bits, sum and difference never alias
  localparam int unsigned PW = CWM + CWF;

  logic [PW-1:0] ptr_cur;
  logic [PW+1:0] ptr_nxt;
  logic [PW+1:0] ptr_sub;

  // step and size are stored minus one
  assign ptr_nxt = {2'b00, ptr_cur} + {2'b00, cfg_ste} + 1'b1;
  assign ptr_sub = ptr_nxt - ({2'b00, cfg_siz} + 1'b1);

  // offset load wins over a step
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (pipe_adv) begin
      if (ptr_ld) begin
        ptr_cur <= cfg_off;
      end else if (ptr_en) begin
        // wrap once the sum reaches the table length
        ptr_cur <= ptr_sub[PW+1] ? ptr_nxt[PW-1:0] : ptr_sub[PW-1:0];
      end
    end
  end

  // integer part
  assign rd_adr = ptr_cur[CWF +: CWM];

endmodule

// File: source/asg_table.sv
//////////////////////////////////////////////////
// waveform table RAM
// CPU read/write port with one cycle ack
// registered stream read port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_table #(
  parameter int unsigned CWM = 14
) (
  input  logic              sto,
  input  logic              ctl_rst,
  input  asg_pkg::bus_req_t bus_req,
  input  logic              pipe_adv,
  input  logic              rd_en,
  input  logic [CWM-1:0]    rd_adr,
  output asg_pkg::smp_t     bus_rdata,
  output logic              bus_ack,
  output asg_pkg::smp_t     rd_dat,
  output logic              rd_vld
);

  asg_pkg::smp_t mem [2**CWM];

  logic [CWM-1:0] bus_adr;

  // word address, low bits only
  assign bus_adr = bus_req.addr[CWM-1:0];

  //////////////////////////////////////////////////
  // CPU port
  //////////////////////////////////////////////////

  // write first, a write returns the new word
  always_ff @(posedge sto) begin
    if (bus_req.wen) begin
      mem[bus_adr] <= bus_req.wdata;
    end
    if (bus_req.wen | bus_req.ren) begin
      bus_rdata <= bus_req.wen ? bus_req.wdata : mem[bus_adr];
    end
  end

  // ack one cycle after any access, no back-pressure
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= bus_req.wen | bus_req.ren;
    end
  end

  //////////////////////////////////////////////////
  // stream port
  //////////////////////////////////////////////////

  // data holds when no read is issued
  always_ff @(posedge sto) begin
    if (pipe_adv & rd_en) begin
      rd_dat <= mem[rd_adr];
    end
  end

  // read request delayed to the data
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      rd_vld <= 1'b0;
    end else if (pipe_adv) begin
      rd_vld <= rd_en;
    end
  end

endmodule

// File: source/asg_out.sv
//////////////////////////////////////////////////
// stream output register with valid/ready
// pipeline advance and last event
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_out (
  input  logic              sto,
  input  logic              ctl_rst,
  input  logic              rd_vld,
  input  asg_pkg::smp_t     rd_dat,
  input  logic              rd_lst_d,
  input  logic              out_rdy,
  output logic              out_vld,
  output asg_pkg::stm_smp_t out_smp,
  output logic              pipe_adv,
  output logic              evn_lst
);

  // move on when the sample is taken or the stage is empty
  assign pipe_adv = out_rdy | ~out_vld;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      out_vld <= 1'b0;
    end else if (pipe_adv) begin
      out_vld <= rd_vld;
    end
  end

  // payload, steady while stalled
  always_ff @(posedge sto) begin
    if (pipe_adv) begin
      out_smp.dat <= rd_dat;
      out_smp.lst <= rd_lst_d;
    end
  end

  // last sample on the output
  assign evn_lst = out_vld & out_smp.lst;

endmodule

// File: source/asg.sv
//////////////////////////////////////////////////
// arbitrary signal generator, one channel
// control, burst counters, pointer, table, output
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg #(
  parameter int unsigned CWM = 14,
  parameter int unsigned CWF = 16
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // run control and status
  input  logic               ctl_str,
  input  logic               ctl_stp,
  input  logic               ctl_trg,
  output logic               sts_str,
  output logic               sts_trg,
  output logic               evn_per,
  output logic               evn_lst,
  // periodic mode, fixed point
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_ste,
  input  logic [CWM+CWF-1:0] cfg_off,
  // burst mode
  input  asg_pkg::bst_cfg_t  cfg_bst,
  output asg_pkg::bln_t      sts_bln,
  output asg_pkg::bnm_t      sts_bnm,
  // CPU bus
  input  asg_pkg::bus_req_t  bus_req,
  output asg_pkg::smp_t      bus_rdata,
  output logic               bus_ack,
  // sample stream
  output logic               out_vld,
  input  logic               out_rdy,
  output asg_pkg::stm_smp_t  out_smp
);

  logic           pipe_adv;
  logic           ptr_ld;
  logic           ptr_en;
  logic           rd_en;
  logic           rd_lst;
  logic           rd_lst_d;
  logic           cnt_clr;
  logic           cnt_en;
  logic           end_bdl;
  logic           end_bln;
  logic           end_bnm;
  logic [CWM-1:0] rd_adr;
  asg_pkg::smp_t  rd_dat;
  logic           rd_vld;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  asg_ctl u_ctl (
    .sto, .ctl_rst, .ctl_str, .ctl_stp, .ctl_trg, .cfg_bst, .pipe_adv,
    .end_bdl, .end_bln, .end_bnm, .sts_str, .sts_trg, .ptr_ld, .ptr_en,
    .rd_en, .rd_lst, .cnt_clr, .cnt_en, .evn_per
  );

  asg_burst_cnt u_burst_cnt (
    .sto, .ctl_rst, .pipe_adv, .cnt_clr, .cnt_en, .cfg_bst,
    .sts_bln, .sts_bnm, .end_bdl, .end_bln, .end_bnm
  );

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  asg_ptr #(.CWM(CWM), .CWF(CWF)) u_ptr (
    .sto, .ctl_rst, .pipe_adv, .ptr_ld, .ptr_en,
    .cfg_siz, .cfg_ste, .cfg_off, .rd_adr
  );

  asg_table #(.CWM(CWM)) u_table (
    .sto, .ctl_rst, .bus_req, .pipe_adv, .rd_en, .rd_adr,
    .bus_rdata, .bus_ack, .rd_dat, .rd_vld
  );

  // last flag follows the table read by one stage
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      rd_lst_d <= 1'b0;
    end else if (pipe_adv) begin
      rd_lst_d <= rd_lst;
    end
  end

  asg_out u_out (
    .sto, .ctl_rst, .rd_vld, .rd_dat, .rd_lst_d, .out_rdy,
    .out_vld, .out_smp, .pipe_adv, .evn_lst
  );

endmodule

// File: testbench/asg_assertions.sv
//////////////////////////////////////////////////
// concurrent checks bound into the generator
// reset values, bus ack, stall hold, latency,
// start before trigger, last sample, period event
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_assertions (
  input logic              sto,
  input logic              ctl_rst,
  input logic              ctl_str,
  input logic              ctl_trg,
  input logic              sts_str,
  input logic              sts_trg,
  input logic              evn_per,
  input logic              evn_lst,
  input asg_pkg::bus_req_t bus_req,
  input logic              bus_ack,
  input logic              out_vld,
  input logic              out_rdy,
  input asg_pkg::stm_smp_t out_smp
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // everything quiet one cycle into reset
  a_rst: assert property (@(posedge sto)
    ctl_rst |=> !out_vld && !sts_str && !sts_trg && !evn_per && !evn_lst && !bus_ack)
    else begin $error("outputs not idle after reset"); fail_cnt++; end

  // ack exactly one cycle after each access
  a_ack: assert property (@(posedge sto) disable iff (ctl_rst)
    (bus_req.wen || bus_req.ren) |=> bus_ack)
    else begin $error("bus_ack missing after a request"); fail_cnt++; end
  a_ack_idle: assert property (@(posedge sto) disable iff (ctl_rst)
    !(bus_req.wen || bus_req.ren) |=> !bus_ack)
    else begin $error("bus_ack without a request"); fail_cnt++; end

  // stalled sample must not move
  a_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    out_vld && !out_rdy |=> out_vld && $stable(out_smp))
    else begin $error("out_smp changed while stalled"); fail_cnt++; end

  // 2 cycles trigger to first valid
  a_lat: assert property (@(posedge sto) disable iff (ctl_rst)
    $rose(sts_trg) && !out_vld |=> !out_vld ##1 out_vld)
    else begin $error("first out_vld not 2 cycles after the trigger"); fail_cnt++; end

  // a run needs a trigger and an armed or starting FSM
  a_start: assert property (@(posedge sto) disable iff (ctl_rst)
    $rose(sts_trg) |-> $past(ctl_trg) && ($past(sts_str) || $past(ctl_str)))
    else begin $error("run started without start and trigger"); fail_cnt++; end

  // last event together with the flagged sample only
  a_evn_lst: assert property (@(posedge sto) disable iff (ctl_rst)
    evn_lst == (out_vld && out_smp.lst))
    else begin $error("evn_lst does not match the last sample"); fail_cnt++; end

  // nothing after the last sample
  a_last: assert property (@(posedge sto) disable iff (ctl_rst)
    out_vld && out_smp.lst && out_rdy |=> !out_vld)
    else begin $error("out_vld high after the last sample"); fail_cnt++; end

  a_per: assert property (@(posedge sto) disable iff (ctl_rst)
    evn_per |=> !evn_per)
    else begin $error("evn_per longer than one cycle"); fail_cnt++; end

endmodule

// File: testbench/asg_tb.sv
//////////////////////////////////////////////////
// testbench for the signal generator
// table load/readback, periodic, back-pressure,
// finite and infinite burst, reset and latency
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_tb;

  localparam int unsigned CWM = 6;
  localparam int unsigned CWF = 4;
  localparam int unsigned PW  = CWM + CWF;
  // 40 entry table, step 2.75, offset 5.5, in 1/16 units
  localparam int SIZ   = 40 * 16 - 1;
  localparam int STE   = 44 - 1;
  localparam int OFF   = 88;
  localparam int N_PER = 100;
  // 4 data samples of 8 per period, 3 periods
  localparam int BDL = 3;
  localparam int BLN = 7;
  localparam int BNM = 2;
  // rough test lengths in cycles
  localparam int L_BUS  = 64 * 6;
  localparam int L_PER  = N_PER + 40;
  localparam int L_BP   = 3 * N_PER + 40;
  localparam int L_BST  = 3 * (BLN + 1) * 3 + 40;
  localparam int L_INF  = 4 * (BLN + 1) + 60;
  localparam int L_RST  = 60;
  localparam int WD_CYC = 4 * (L_BUS + 2 * L_PER + L_BP + L_BST + L_INF + L_RST);

  logic sto = 1'b0;
  logic ctl_rst;
  logic ctl_str;
  logic ctl_stp;
  logic ctl_trg;
  logic sts_str;
  logic sts_trg;
  logic evn_per;
  logic evn_lst;
  logic [PW-1:0] cfg_siz;
  logic [PW-1:0] cfg_ste;
  logic [PW-1:0] cfg_off;
  asg_pkg::bst_cfg_t cfg_bst;
  asg_pkg::bln_t sts_bln;
  asg_pkg::bnm_t sts_bnm;
  asg_pkg::bus_req_t bus_req;
  asg_pkg::smp_t bus_rdata;
  logic bus_ack;
  logic out_vld;
  logic out_rdy;
  asg_pkg::stm_smp_t out_smp;

  logic [15:0] lfsr = 16'd7553;
  logic rdy_rnd = 1'b0;
  asg_pkg::stm_smp_t rx_q [$];
  int per_cnt = 0;
  int err_cnt = 0;

  asg #(.CWM(CWM), .CWF(CWF)) dut (.*);

  bind asg asg_assertions u_asrt (
    .sto, .ctl_rst, .ctl_str, .ctl_trg, .sts_str, .sts_trg, .evn_per, .evn_lst,
    .bus_req, .bus_ack, .out_vld, .out_rdy, .out_smp
  );

  always #5 sto = ~sto;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic asg_pkg::smp_t tbl(input int a);
    return asg_pkg::smp_t'((a * 37 + 5) % 16384);
  endfunction

  // integer part after m steps from the offset
  function automatic int ptr_idx(input int m);
    int p;
    p = OFF;
    for (int i = 0; i < m; i++) begin
      p = p + STE + 1;
      if (p >= SIZ + 1) begin
        p = p - (SIZ + 1);
      end
    end
    return p >> CWF;
  endfunction

  // burst gap repeats the last data sample
  function automatic asg_pkg::smp_t exp_smp(input int n, input logic bst);
    int m;
    if (bst) begin
      m = (n / (BLN + 1)) * (BDL + 1) + ((n % (BLN + 1)) > BDL ? BDL : n % (BLN + 1));
    end else begin
      m = n;
    end
    return tbl(ptr_idx(m));
  endfunction

  //////////////////////////////////////////////////
  // drivers and monitor
  //////////////////////////////////////////////////

  initial begin
    out_rdy = 1'b1;
    forever begin
      @(negedge sto);
      if (rdy_rnd) begin
        lfsr = lfsr_next(lfsr);
        out_rdy = lfsr[0];
      end else begin
        out_rdy = 1'b1;
      end
    end
  end

  // stream transfers and period events
  always @(posedge sto) begin
    if (!ctl_rst && out_vld && out_rdy) begin
      rx_q.push_back(out_smp);
    end
    if (!ctl_rst && evn_per) begin
      per_cnt++;
    end
  end

  task automatic bus_access(input logic wr, input int a);
    @(negedge sto);
    bus_req.wen   = wr;
    bus_req.ren   = ~wr;
    bus_req.addr  = asg_pkg::bus_adr_t'(a);
    bus_req.wdata = tbl(a);
    @(negedge sto);
    bus_req = '0;
    if (!bus_ack) begin
      $display("bus access to address %0d got no ack", a);
      err_cnt++;
    end else if (!wr && bus_rdata !== tbl(a)) begin
      $display("FAILED bus_rdata[%0d] exp %h got %h", a, tbl(a), bus_rdata);
      err_cnt++;
    end
  endtask

  task automatic pulse(input logic str, input logic trg);
    @(negedge sto);
    ctl_str = str;
    ctl_trg = trg;
    @(negedge sto);
    ctl_str = 1'b0;
    ctl_trg = 1'b0;
  endtask

  task automatic wait_last(input int base);
    while (!(rx_q.size() > base && rx_q[$].lst)) begin
      @(negedge sto);
    end
    // out_vld must stay low from here on
    repeat (4) @(negedge sto);
  endtask

  // stop is held until the FSM takes it
  task automatic stop_run(input int base);
    @(negedge sto);
    ctl_stp = 1'b1;
    while (sts_str) begin
      @(negedge sto);
    end
    ctl_stp = 1'b0;
    wait_last(base);
  endtask

  task automatic check_rx(input int base, input logic bst, input int n_min, input int n_max);
    int n;
    n = rx_q.size() - base;
    if (n < n_min || n > n_max) begin
      $display("got %0d samples, expected %0d to %0d", n, n_min, n_max);
      err_cnt++;
    end
    for (int i = 0; i < n; i++) begin
      if (rx_q[base + i].dat !== exp_smp(i, bst)) begin
        $display("FAILED out_smp.dat[%0d] exp %h got %h", i, exp_smp(i, bst),
                 rx_q[base + i].dat);
        err_cnt++;
      end
      if (rx_q[base + i].lst !== (i == n - 1)) begin
        $display("FAILED out_smp.lst[%0d] exp %h got %h", i, i == n - 1, rx_q[base + i].lst);
        err_cnt++;
      end
    end
  endtask

  // one run cycle per sample, period count wraps into repetitions
  task automatic check_cnt(input int base);
    int n;
    n = rx_q.size() - base;
    if (sts_bln !== asg_pkg::bln_t'(n % (BLN + 1))) begin
      $display("FAILED sts_bln exp %h got %h", n % (BLN + 1), sts_bln);
      err_cnt++;
    end
    if (sts_bnm !== asg_pkg::bnm_t'(n / (BLN + 1))) begin
      $display("FAILED sts_bnm exp %h got %h", n / (BLN + 1), sts_bnm);
      err_cnt++;
    end
  endtask

  task automatic run_periodic();
    int base;
    base = rx_q.size();
    pulse(1'b1, 1'b0);
    pulse(1'b0, 1'b1);
    while (rx_q.size() - base < N_PER) begin
      @(negedge sto);
    end
    stop_run(base);
    check_rx(base, 1'b0, N_PER, N_PER + 8);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int base;
    int per_base;
    int lat;
    ctl_rst = 1'b1;
    ctl_str = 1'b0;
    ctl_stp = 1'b0;
    ctl_trg = 1'b0;
    cfg_siz = PW'(SIZ);
    cfg_ste = PW'(STE);
    cfg_off = PW'(OFF);
    cfg_bst = '0;
    bus_req = '0;
    repeat (8) @(negedge sto);
    ctl_rst = 1'b0;

    for (int a = 0; a < 2**CWM; a++) begin
      bus_access(1'b1, a);
    end
    for (int a = 0; a < 2**CWM; a++) begin
      bus_access(1'b0, a);
    end

    // trigger while stopped
    pulse(1'b0, 1'b1);
    repeat (4) @(negedge sto);
    if (sts_str || sts_trg || out_vld) begin
      $display("trigger was accepted before start");
      err_cnt++;
    end
    run_periodic();

    // same run under random back-pressure
    rdy_rnd = 1'b1;
    run_periodic();

    // finite burst, start and trigger in one cycle
    cfg_bst.ben = 1'b1;
    cfg_bst.bdl = asg_pkg::bln_t'(BDL);
    cfg_bst.bln = asg_pkg::bln_t'(BLN);
    cfg_bst.bnm = asg_pkg::bnm_t'(BNM);
    base = rx_q.size();
    per_base = per_cnt;
    pulse(1'b1, 1'b1);
    wait_last(base);
    check_rx(base, 1'b1, (BNM + 1) * (BLN + 1), (BNM + 1) * (BLN + 1));
    check_cnt(base);
    if (per_cnt - per_base != BNM + 1) begin
      $display("FAILED evn_per count exp %h got %h", BNM + 1, per_cnt - per_base);
      err_cnt++;
    end

    // infinite burst until stop
    rdy_rnd = 1'b0;
    cfg_bst.inf = 1'b1;
    cfg_bst.bnm = '0;
    base = rx_q.size();
    per_base = per_cnt;
    pulse(1'b1, 1'b1);
    while (per_cnt - per_base < 3) begin
      @(negedge sto);
    end
    stop_run(base);
    check_rx(base, 1'b1, 2 * (BLN + 1), 5 * (BLN + 1));
    check_cnt(base);

    // second reset, then trigger to first valid
    cfg_bst = '0;
    ctl_rst = 1'b1;
    repeat (8) @(negedge sto);
    ctl_rst = 1'b0;
    base = rx_q.size();
    pulse(1'b1, 1'b0);
    pulse(1'b0, 1'b1);
    lat = 0;
    while (!out_vld && lat < 10) begin
      @(negedge sto);
      lat++;
    end
    if (lat != 2) begin
      $display("FAILED out_vld latency exp %h got %h", 2, lat);
      err_cnt++;
    end
    stop_run(base);
    check_rx(base, 1'b0, 1, 8);

    $display("errors: %0d checks, %0d assertions", err_cnt, dut.u_asrt.fail_cnt);
    if (err_cnt == 0 && dut.u_asrt.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WD_CYC) @(posedge sto);
    $display("timeout, the tests did not finish within %0d cycles", WD_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: asg.f
source/asg_pkg.sv
source/asg_ctl.sv
source/asg_burst_cnt.sv
source/asg_ptr.sv
source/asg_table.sv
source/asg_out.sv
source/asg.sv
testbench/asg_assertions.sv
testbench/asg_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = asg_tb
FLIST      = asg.f
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+1000
PASS       = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJ_DIR)
